// ==== source/ca_tx_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types for the transmit channel-alignment slice
// Holds the channel width, the alignment tag encoding and
// the word and location structs used by every stage
// Modules import it inside their body and use scoped names
// in their port lists
////////////////////////////////////////////////////////////

`default_nettype none

package ca_tx_pkg;

  // Width of one channel word on the die-to-die link
  localparam int CA_CH_WIDTH = 80;

  ////////////////////////////////////////////////////////////
  // Insertion location
  ////////////////////////////////////////////////////////////

  // Bit position of an alignment bit for each link generation
  // The active field is picked by gen2_mode at the insertion mux
  typedef struct packed {
    logic [8:0] gen1_loc;
    logic [8:0] gen2_loc;
  } ca_loc_t;

  ////////////////////////////////////////////////////////////
  // Alignment tag
  ////////////////////////////////////////////////////////////

  // Bit 0 flags a recoverable strobe, bit 1 a persistent marker
  // TAG_BOTH means the word carries both kinds of bit
  typedef enum logic [1:0] {
    TAG_NONE   = 2'b00,
    TAG_STROBE = 2'b01,
    TAG_MARKER = 2'b10,
    TAG_BOTH   = 2'b11
  } ca_tag_e;

  ////////////////////////////////////////////////////////////
  // Tagged channel word
  ////////////////////////////////////////////////////////////

  // Payload plus its tag, 82 bits in all
  // Travels from the producer through the buffer to the consumer
  typedef struct packed {
    logic [CA_CH_WIDTH-1:0] data;
    ca_tag_e                tag;
  } ca_word_t;

endpackage

`default_nettype wire

// ==== source/ca_tx_marker_gen.sv ====
////////////////////////////////////////////////////////////
// Word producer for the transmit alignment path
// Numbers every accepted input word and tags it as a strobe
// word, a marker word, both or neither, then registers the
// tagged word toward the buffer with a one-cycle push
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_marker_gen #(
  parameter int STROBE_PERIOD = 4,
  parameter int MARKER_PERIOD = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [ca_tx_pkg::CA_CH_WIDTH-1:0]  in_data,
  input  logic                               in_valid,
  output ca_tx_pkg::ca_word_t                push_word,
  output logic                               push
);

  import ca_tx_pkg::*;

  // Counter widths, kept at one bit for a period of one
  localparam int SCNT_W = (STROBE_PERIOD > 1) ? $clog2(STROBE_PERIOD) : 1;
  localparam int MCNT_W = (MARKER_PERIOD > 1) ? $clog2(MARKER_PERIOD) : 1;

  // Word number modulo each period
  logic [SCNT_W-1:0] strobe_cnt;
  logic [MCNT_W-1:0] marker_cnt;
  logic              is_strobe;
  logic              is_marker;
  ca_tag_e           word_tag;

  ////////////////////////////////////////////////////////////
  // Tag decode
  ////////////////////////////////////////////////////////////

  // Strobe on word numbers that are a multiple of the period
  assign is_strobe = (strobe_cnt == '0);
  // Marker on the last word of every marker period
  assign is_marker = (marker_cnt == MCNT_W'(MARKER_PERIOD - 1));

  always_comb
  begin
    case ({is_marker, is_strobe})
      2'b01:   word_tag = TAG_STROBE;
      2'b10:   word_tag = TAG_MARKER;
      2'b11:   word_tag = TAG_BOTH;
      default: word_tag = TAG_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counters and output register
  ////////////////////////////////////////////////////////////

  // The counters only move on accepted words
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      strobe_cnt <= '0;
      marker_cnt <= '0;
      push       <= 1'b0;
    end
    else
    begin
      push <= in_valid;
      if (in_valid)
      begin
        strobe_cnt <= (strobe_cnt == SCNT_W'(STROBE_PERIOD - 1)) ? '0 : strobe_cnt + 1'b1;
        marker_cnt <= (marker_cnt == MCNT_W'(MARKER_PERIOD - 1)) ? '0 : marker_cnt + 1'b1;
      end
    end
  end

  // Payload register, qualified by push downstream
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      push_word.data <= in_data;
      push_word.tag  <= word_tag;
    end
  end

endmodule

`default_nettype wire

// ==== source/ca_tx_word_fifo.sv ====
////////////////////////////////////////////////////////////
// Holding buffer for tagged words
// Circular buffer that fills while the link holds off and is
// drained one word per pop; a push into a full buffer with no
// pop in the same cycle is dropped and sets sticky overflow
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_word_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ca_tx_pkg::ca_word_t  push_word,
  input  logic                 push,
  input  logic                 pop,
  output ca_tx_pkg::ca_word_t  head_word,
  output logic                 empty,
  output logic                 overflow
);

  import ca_tx_pkg::*;

  // FIFO_DEPTH is a power of two, so the pointers wrap by themselves
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  ca_word_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  ////////////////////////////////////////////////////////////
  // Status and accept logic
  ////////////////////////////////////////////////////////////

  assign empty = (count == '0);
  assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

  // A pop on an empty buffer does nothing
  assign do_pop  = pop && !empty;
  // A pop in the same cycle frees the slot for a full buffer
  assign do_push = push && (!full || do_pop);

  // The oldest word is always presented at the head
  assign head_word = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy and overflow
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset
      if (push && !do_push)
        overflow <= 1'b1;
    end
  end

  // Storage array
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_word;
  end

endmodule

`default_nettype wire

// ==== source/ca_tx_mux.sv ====
////////////////////////////////////////////////////////////
// Alignment bit insertion mux
// PERSISTENT 0 overwrites one bit with the user bit and is
// bypassed when online; PERSISTENT 1 splices the user bit in
// and moves the bits above it up by one, losing the top bit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_mux #(
  parameter int PERSISTENT = 0,
  parameter int CH_WIDTH   = 80
) (
  input  logic [CH_WIDTH-1:0] data_in,
  output logic [CH_WIDTH-1:0] data_out,
  input  logic                online,
  input  logic                gen2_mode,
  input  ca_tx_pkg::ca_loc_t  loc,
  input  logic                user_bit
);

  logic [8:0]          sel_loc;
  logic [CH_WIDTH-1:0] loc_onehot;
  logic [CH_WIDTH-1:0] user_data;
  logic [CH_WIDTH-1:0] mask_low;
  logic [CH_WIDTH-1:0] mask_high;
  logic                found_loc;

  ////////////////////////////////////////////////////////////
  // Location decode
  ////////////////////////////////////////////////////////////

  // Generation 2 uses its own bit position
  assign sel_loc = gen2_mode ? loc.gen2_loc : loc.gen1_loc;

  // One-hot vector at the insertion point
  // A location past the word width gives all zeros and no insertion
  assign loc_onehot = {{(CH_WIDTH - 1){1'b0}}, 1'b1} << sel_loc;

  // Only the insertion bit can be set here
  assign user_data = loc_onehot & {CH_WIDTH{user_bit}};

  // Low mask covers bits below the location, high mask the rest
  always_comb
  begin
    found_loc = 1'b0;
    for (int i = 0; i < CH_WIDTH; i++)
    begin
      found_loc    = found_loc | loc_onehot[i];
      mask_low[i]  = !found_loc;
      mask_high[i] = found_loc;
    end
  end

  ////////////////////////////////////////////////////////////
  // Insertion form
  ////////////////////////////////////////////////////////////

  generate
    if (PERSISTENT != 0)
    begin : g_splice
      // The bit at the location and everything above shift up one
      assign data_out = user_data
                      | ((data_in & mask_high) << 1)
                      | (data_in & mask_low);
    end
    else
    begin : g_overwrite
      // Recoverable strobe, dropped once the link is online
      assign data_out = online ? data_in : (user_data | (~loc_onehot & data_in));
    end
  endgenerate

endmodule

`default_nettype wire

// ==== source/ca_tx_insert.sv ====
////////////////////////////////////////////////////////////
// Word consumer and insertion stage
// Pops the buffer head whenever the link is not holding off,
// splices the marker, overwrites the strobe and registers the
// final word with its valid
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_insert (
  input  logic                              clk,
  input  logic                              reset,
  input  ca_tx_pkg::ca_word_t               head_word,
  input  logic                              empty,
  input  logic                              tx_hold,
  input  logic                              online,
  input  logic                              gen2_mode,
  input  ca_tx_pkg::ca_loc_t                strobe_loc,
  input  ca_tx_pkg::ca_loc_t                marker_loc,
  output logic                              pop,
  output logic [ca_tx_pkg::CA_CH_WIDTH-1:0] out_data,
  output logic                              out_valid
);

  import ca_tx_pkg::*;

  logic                   marker_bit;
  logic                   strobe_bit;
  logic [CA_CH_WIDTH-1:0] spliced_data;
  logic [CA_CH_WIDTH-1:0] final_data;

  // Drain one word per cycle unless the link holds off
  assign pop = !empty && !tx_hold;

  // User bits follow the tag of the head word
  assign marker_bit = (head_word.tag == TAG_MARKER) || (head_word.tag == TAG_BOTH);
  assign strobe_bit = (head_word.tag == TAG_STROBE) || (head_word.tag == TAG_BOTH);

  ////////////////////////////////////////////////////////////
  // Marker splice, then strobe overwrite
  ////////////////////////////////////////////////////////////

  ca_tx_mux #(
    .PERSISTENT (1),
    .CH_WIDTH   (CA_CH_WIDTH)
  ) marker_mux0 (
    .data_in   (head_word.data),
    .data_out  (spliced_data),
    .online    (online),
    .gen2_mode (gen2_mode),
    .loc       (marker_loc),
    .user_bit  (marker_bit)
  );

  ca_tx_mux #(
    .PERSISTENT (0),
    .CH_WIDTH   (CA_CH_WIDTH)
  ) strobe_mux0 (
    .data_in   (spliced_data),
    .data_out  (final_data),
    .online    (online),
    .gen2_mode (gen2_mode),
    .loc       (strobe_loc),
    .user_bit  (strobe_bit)
  );

  // Output valid follows pop by one cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else
      out_valid <= pop;
  end

  // Output word, only meaningful with out_valid
  always_ff @(posedge clk)
  begin
    if (pop)
      out_data <= final_data;
  end

endmodule

`default_nettype wire

// ==== source/ca_tx_channel.sv ====
////////////////////////////////////////////////////////////
// Transmit channel-alignment slice, top level
// Producer tags words, the buffer holds them during tx_hold
// and the consumer inserts the alignment bits; latency from
// in_valid to out_valid is 2 cycles with an empty buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_channel #(
  parameter int FIFO_DEPTH    = 8,
  parameter int STROBE_PERIOD = 4,
  parameter int MARKER_PERIOD = 3
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [ca_tx_pkg::CA_CH_WIDTH-1:0] in_data,
  input  logic                              in_valid,
  input  logic                              tx_hold,
  input  logic                              online,
  input  logic                              gen2_mode,
  input  ca_tx_pkg::ca_loc_t                strobe_loc,
  input  ca_tx_pkg::ca_loc_t                marker_loc,
  output logic [ca_tx_pkg::CA_CH_WIDTH-1:0] out_data,
  output logic                              out_valid,
  output logic                              overflow
);

  import ca_tx_pkg::*;

  // Producer to buffer
  ca_word_t push_word;
  logic     push;
  // Buffer to consumer and back
  ca_word_t head_word;
  logic     empty;
  logic     pop;

  ca_tx_marker_gen #(
    .STROBE_PERIOD (STROBE_PERIOD),
    .MARKER_PERIOD (MARKER_PERIOD)
  ) producer0 (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .push_word (push_word),
    .push      (push)
  );

  ca_tx_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk       (clk),
    .reset     (reset),
    .push_word (push_word),
    .push      (push),
    .pop       (pop),
    .head_word (head_word),
    .empty     (empty),
    .overflow  (overflow)
  );

  ca_tx_insert insert0 (
    .clk        (clk),
    .reset      (reset),
    .head_word  (head_word),
    .empty      (empty),
    .tx_hold    (tx_hold),
    .online     (online),
    .gen2_mode  (gen2_mode),
    .strobe_loc (strobe_loc),
    .marker_loc (marker_loc),
    .pop        (pop),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

// ==== tests/ca_tx_channel_sva.sv ====
////////////////////////////////////////////////////////////
// Concurrent assertions for the channel-alignment top level
// Bound into ca_tx_channel to watch hold, buffer and overflow
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_channel_sva (
  input logic clk,
  input logic reset,
  input logic tx_hold,
  input logic out_valid,
  input logic overflow,
  input logic pop,
  input logic empty
);

  // Hold blocks the pop, so nothing leaves in the next cycle
  a_hold_blocks_valid: assert property (@(posedge clk) disable iff (reset)
    tx_hold |=> !out_valid)
    else $error("out_valid high in the cycle after tx_hold");

  // Overflow is sticky until reset
  a_overflow_sticky: assert property (@(posedge clk) disable iff (reset)
    overflow |=> overflow)
    else $error("overflow fell without reset");

  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
    empty |-> !pop)
    else $error("pop asserted on an empty buffer");

endmodule

`default_nettype wire

// ==== tests/ca_tx_channel_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the transmit channel-alignment slice
// Applies a table of stream, hold and online phases, keeps
// a cycle model of tagging, buffering and bit insertion and
// compares every output cycle against it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ca_tx_channel_tb;

  import ca_tx_pkg::*;

  localparam int FIFO_DEPTH    = 8;
  localparam int STROBE_PERIOD = 4;
  localparam int MARKER_PERIOD = 3;
  localparam int RESET_CYCLES  = 16;
  localparam int NUM_ROWS      = 9;

  // One phase of stimulus, held for a number of cycles
  typedef struct packed {
    logic       in_valid;
    logic       tx_hold;
    logic       online;
    logic       gen2_mode;
    logic [7:0] cycles;
  } stim_row_t;

  logic                   clk;
  logic                   reset;
  logic [CA_CH_WIDTH-1:0] in_data;
  logic                   in_valid;
  logic                   tx_hold;
  logic                   online;
  logic                   gen2_mode;
  ca_loc_t                strobe_loc;
  ca_loc_t                marker_loc;
  logic [CA_CH_WIDTH-1:0] out_data;
  logic                   out_valid;
  logic                   overflow;

  stim_row_t stim_table [NUM_ROWS];
  int        cycle_limit;
  int        cycle_count;
  int        error_count;

  // Model state, updated at each rising edge
  int        word_num;
  logic      m_push;
  ca_word_t  m_push_word;
  ca_word_t  model_queue [$];
  logic      exp_valid;
  ca_word_t  exp_word;
  logic      exp_overflow;

  ca_tx_channel #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .STROBE_PERIOD (STROBE_PERIOD),
    .MARKER_PERIOD (MARKER_PERIOD)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .tx_hold    (tx_hold),
    .online     (online),
    .gen2_mode  (gen2_mode),
    .strobe_loc (strobe_loc),
    .marker_loc (marker_loc),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .overflow   (overflow)
  );

  bind ca_tx_channel ca_tx_channel_sva sva0 (
    .clk       (clk),
    .reset     (reset),
    .tx_hold   (tx_hold),
    .out_valid (out_valid),
    .overflow  (overflow),
    .pop       (pop),
    .empty     (empty)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Strobe on multiples of the strobe period, marker on the last word of a marker period
  function automatic ca_tag_e tag_for_number(input int num);
    logic strobe_hit;
    logic marker_hit;
    strobe_hit = (num % STROBE_PERIOD) == 0;
    marker_hit = (num % MARKER_PERIOD) == (MARKER_PERIOD - 1);
    if (strobe_hit && marker_hit)
      return TAG_BOTH;
    if (marker_hit)
      return TAG_MARKER;
    if (strobe_hit)
      return TAG_STROBE;
    return TAG_NONE;
  endfunction

  // Marker splice bit by bit, then the strobe overwrite unless online
  function automatic logic [CA_CH_WIDTH-1:0] insert_bits(input ca_word_t w, input logic on,
                                                         input logic g2);
    logic [CA_CH_WIDTH-1:0] result;
    int                     m_loc;
    int                     s_loc;
    logic                   m_bit;
    logic                   s_bit;
    m_loc = g2 ? int'(marker_loc.gen2_loc) : int'(marker_loc.gen1_loc);
    s_loc = g2 ? int'(strobe_loc.gen2_loc) : int'(strobe_loc.gen1_loc);
    m_bit = (w.tag == TAG_MARKER) || (w.tag == TAG_BOTH);
    s_bit = (w.tag == TAG_STROBE) || (w.tag == TAG_BOTH);
    for (int i = 0; i < CA_CH_WIDTH; i++)
    begin
      if (i < m_loc)
        result[i] = w.data[i];
      else if (i == m_loc)
        result[i] = m_bit;
      else
        result[i] = w.data[i - 1];
    end
    if (!on)
      result[s_loc] = s_bit;
    return result;
  endfunction

  // Called at a rising edge before new inputs are driven, so it sees what the DUT samples
  task automatic model_edge();
    logic     pop_now;
    ca_word_t head;
    pop_now   = (model_queue.size() > 0) && !tx_hold;
    exp_valid = pop_now;
    if (pop_now)
    begin
      head          = model_queue.pop_front();
      exp_word.tag  = head.tag;
      exp_word.data = insert_bits(head, online, gen2_mode);
    end
    // A pop in the same edge makes room in a full buffer
    if (m_push)
    begin
      if (model_queue.size() < FIFO_DEPTH)
        model_queue.push_back(m_push_word);
      else
        exp_overflow = 1'b1;
    end
    m_push = in_valid;
    if (in_valid)
    begin
      m_push_word.data = in_data;
      m_push_word.tag  = tag_for_number(word_num);
      word_num++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input ca_word_t expected, input logic [CA_CH_WIDTH-1:0] actual,
                            input string what);
    if (actual !== expected.data)
    begin
      error_count++;
      $display("CHECK FAILED at time %0t: %s (tag %s) expected %h got %h",
               $time, what, expected.tag.name(), expected.data, actual);
      $display("sim failed");
      $fatal(1, "output word mismatch");
    end
  endtask

  task automatic check_flag(input logic expected, input logic actual, input string what);
    if (actual !== expected)
    begin
      error_count++;
      $display("CHECK FAILED at time %0t: %s expected %b got %b",
               $time, what, expected, actual);
      $display("sim failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // One clock of a row with the outputs compared at the falling edge
  task automatic step_cycle(input stim_row_t row);
    logic [95:0] rand_bits;
    @(posedge clk);
    model_edge();
    rand_bits = {$urandom, $urandom, $urandom};
    in_valid  <= row.in_valid;
    tx_hold   <= row.tx_hold;
    online    <= row.online;
    gen2_mode <= row.gen2_mode;
    in_data   <= rand_bits[CA_CH_WIDTH-1:0];
    @(negedge clk);
    check_flag(exp_valid, out_valid, "out_valid");
    if (exp_valid)
      check_word(exp_word, out_data, "out_data");
    check_flag(exp_overflow, overflow, "overflow");
  endtask

  function automatic int table_cycles();
    int total;
    total = 0;
    foreach (stim_table[i])
      total += int'(stim_table[i].cycles);
    return total;
  endfunction

  // Run limit from reset, the table and a full drain
  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $fatal(1, "timeout");
      end
    end
  end

  initial
  begin
    stim_row_t idle_row;
    void'($urandom(32'he2e7));
    // Columns are in_valid, tx_hold, online, gen2_mode, cycles
    stim_table = '{
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd14},  // Gen 1 stream with strobes
      '{1'b1, 1'b0, 1'b0, 1'b1, 8'd12},  // Gen 2 locations
      '{1'b1, 1'b0, 1'b1, 1'b0, 8'd12},  // Online, marker only
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd4},
      '{1'b1, 1'b1, 1'b0, 1'b1, 8'd6},   // Hold below the buffer depth
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd10},
      '{1'b1, 1'b1, 1'b0, 1'b0, 8'd14},  // Hold past the depth, words dropped
      '{1'b1, 1'b0, 1'b1, 1'b1, 8'd12},  // Push and pop on a full buffer
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd12}
    };
    idle_row    = '{1'b0, 1'b0, 1'b0, 1'b0, 8'd1};
    cycle_limit = RESET_CYCLES + table_cycles() + FIFO_DEPTH + 20;
    error_count = 0;

    reset      = 1'b1;
    in_data    = '0;
    in_valid   = 1'b0;
    tx_hold    = 1'b0;
    online     = 1'b0;
    gen2_mode  = 1'b0;
    // Gen 2 strobe above the gen 2 marker makes the splice order visible
    strobe_loc = '{gen1_loc: 9'd3, gen2_loc: 9'd77};
    // Gen 2 marker sits near the top so the lost bit is close by
    marker_loc = '{gen1_loc: 9'd40, gen2_loc: 9'd75};

    word_num     = 0;
    m_push       = 1'b0;
    m_push_word  = '0;
    exp_valid    = 1'b0;
    exp_word     = '0;
    exp_overflow = 1'b0;
    model_queue.delete();

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    foreach (stim_table[r])
    begin
      for (int c = 0; c < int'(stim_table[r].cycles); c++)
        step_cycle(stim_table[r]);
    end

    // Drain whatever the model still holds
    while ((model_queue.size() > 0) || m_push || exp_valid)
      step_cycle(idle_row);

    check_flag(1'b1, overflow, "overflow after the drop phase");

    if (error_count == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
    begin
      $display("sim failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/ca_tx_pkg.sv
source/ca_tx_marker_gen.sv
source/ca_tx_word_fifo.sv
source/ca_tx_mux.sv
source/ca_tx_insert.sv
source/ca_tx_channel.sv
tests/ca_tx_channel_sva.sv
tests/ca_tx_channel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the channel-alignment testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ca_tx_channel_tb -f compile.f

status=0
out=$(./obj_dir/Vca_tx_channel_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
